//--- verilog/dcache_pkg.sv
//////////////////////////////////////////////////////////////////////
// dcache shared definitions
// widths, address fields, request structs and controller states for
// the two-way write-back data cache
//////////////////////////////////////////////////////////////////////

package dcache_pkg;

    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORD_W * WORDS_PER_LINE;   // 128
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 2;
    localparam int NUM_SETS       = 1 << INDEX_W;              // 256
    localparam int NUM_WAYS       = 2;
    localparam int ADDR_W         = TAG_W + INDEX_W + OFFSET_W; // word address
    localparam int LINE_ADDR_W    = TAG_W + INDEX_W;

    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [LINE_W-1:0]            line_t;
    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [INDEX_W-1:0]           index_t;
    typedef logic [OFFSET_W-1:0]          offset_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]  way_t;

    // address layouts, msb first
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } word_addr_t;

    typedef struct packed {
        tag_t   tag;
        index_t index;
    } line_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

    typedef struct packed {
        logic       write;
        word_addr_t addr;
        word_t      wdata;
    } cpu_req_t;

    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_t      wdata;    // victim line, writes only
    } mem_req_t;

    typedef enum logic [2:0] {
        INIT, IDLE, LOOKUP, WRITEBACK, FETCH, WAIT_FILL, FILL
    } ctrl_state_t;

endpackage

//--- verilog/dcache_way_ram.sv
//////////////////////////////////////////////////////////////////////
// dcache way array
// one way's storage of 256 entries, synchronous write and registered
// read, payload type set per instance
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_way_ram #(
    parameter type entry_t = dcache_pkg::line_t
) (
    input  logic                clk,
    input  dcache_pkg::index_t  index,
    input  logic                we,
    input  entry_t              wdata,
    output entry_t              rdata
);

    entry_t mem [dcache_pkg::NUM_SETS];

    // read returns the old entry when written in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
        rdata <= mem[index];
    end

endmodule

//--- verilog/dcache_lru.sv
//////////////////////////////////////////////////////////////////////
// dcache replacement state
// one bit per set naming the least recently used way
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_lru (
    input  logic                clk,
    input  logic                rst_n,
    input  dcache_pkg::index_t  index,
    input  logic                touch,
    input  dcache_pkg::way_t    touch_way,
    output dcache_pkg::way_t    lru_way
);

    dcache_pkg::way_t lru_bits [dcache_pkg::NUM_SETS];

    assign lru_way = lru_bits[index];   // combinational read

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < dcache_pkg::NUM_SETS; i++) begin
                lru_bits[i] <= '0;
            end
        end else if (touch) begin
            lru_bits[index] <= ~touch_way;  // other way becomes lru
        end
    end

    a_touch_known: assert property (@(posedge clk) disable iff (!rst_n)
        touch |-> !$isunknown(touch_way));

endmodule

//--- verilog/dcache_way_select.sv
//////////////////////////////////////////////////////////////////////
// dcache way select
// tag compare, victim choice, read word extraction and the merge of
// the write word into the hit or fill line
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_way_select (
    input  dcache_pkg::cpu_req_t    req,
    input  dcache_pkg::tag_entry_t  tag0,
    input  dcache_pkg::tag_entry_t  tag1,
    input  dcache_pkg::line_t       line0,
    input  dcache_pkg::line_t       line1,
    input  dcache_pkg::way_t        lru_way,
    input  logic                    filling,
    input  dcache_pkg::line_t       fill_line,
    output logic                    hit,
    output dcache_pkg::way_t        hit_way,
    output dcache_pkg::way_t        victim_way,
    output logic                    victim_dirty,
    output dcache_pkg::line_addr_t  victim_addr,
    output dcache_pkg::line_t       victim_line,
    output dcache_pkg::word_t       rdata,
    output dcache_pkg::line_t       new_line
);

    logic                   hit0;
    logic                   hit1;
    dcache_pkg::tag_entry_t victim_tag;
    dcache_pkg::line_t      src_line;

    assign hit0    = tag0.valid && (tag0.tag == req.addr.tag);
    assign hit1    = tag1.valid && (tag1.tag == req.addr.tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit0 ? 1'b0 : 1'b1;

    // invalid way first, way 0 before way 1, then lru
    always_comb begin
        if (!tag0.valid) begin
            victim_way = 1'b0;
        end else if (!tag1.valid) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_way;
        end
    end

    assign victim_tag        = victim_way ? tag1 : tag0;
    assign victim_line       = victim_way ? line1 : line0;
    assign victim_dirty      = victim_tag.valid && victim_tag.dirty;
    assign victim_addr.tag   = victim_tag.tag;
    assign victim_addr.index = req.addr.index;

    assign src_line = filling ? fill_line : (hit_way ? line1 : line0);

    always_comb begin
        rdata    = '0;
        new_line = src_line;
        for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
            if (dcache_pkg::offset_t'(i) == req.addr.offset) begin
                rdata = src_line[i*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
                if (req.write) begin    // reads keep the line as fetched
                    new_line[i*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] = req.wdata;
                end
            end
        end
    end

    // arrays read before the sweep may still be unknown
    a_one_hit: assert final ($isunknown({hit0, hit1}) || !(hit0 && hit1));

endmodule

//--- verilog/dcache_ctrl.sv
//////////////////////////////////////////////////////////////////////
// dcache controller
// blocking FSM with one request in flight, invalidate sweep after
// reset, write-back of dirty victims and line fill from memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cpu_req_valid,
    output logic                                 cpu_req_ready,
    input  dcache_pkg::cpu_req_t                 cpu_req,
    output logic                                 cpu_rsp_valid,
    output logic                                 mem_req_valid,
    input  logic                                 mem_req_ready,
    output dcache_pkg::mem_req_t                 mem_req,
    input  logic                                 mem_rsp_valid,
    input  dcache_pkg::line_t                    mem_rsp_line,
    output dcache_pkg::cpu_req_t                 held_req,
    output dcache_pkg::index_t                   ram_index,
    output logic [dcache_pkg::NUM_WAYS-1:0]      tag_we,
    output logic [dcache_pkg::NUM_WAYS-1:0]      data_we,
    output dcache_pkg::tag_entry_t               tag_wdata,
    output logic                                 filling,
    output dcache_pkg::line_t                    fill_line,
    output logic                                 touch,
    output dcache_pkg::way_t                     touch_way,
    input  logic                                 hit,
    input  dcache_pkg::way_t                     hit_way,
    input  dcache_pkg::way_t                     victim_way,
    input  logic                                 victim_dirty,
    input  dcache_pkg::line_addr_t               victim_addr,
    input  dcache_pkg::line_t                    victim_line
);

    dcache_pkg::ctrl_state_t              state;
    dcache_pkg::ctrl_state_t              next_state;
    dcache_pkg::index_t                   sweep_idx;
    logic [dcache_pkg::LINE_ADDR_W-1:0]   fetch_addr;

    assign fetch_addr = held_req.addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W];
    assign filling    = (state == dcache_pkg::FILL);

    //////////////////////////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        next_state    = state;
        cpu_req_ready = 1'b0;
        cpu_rsp_valid = 1'b0;
        mem_req_valid = 1'b0;
        mem_req       = '0;
        ram_index     = held_req.addr.index;
        tag_we        = '0;
        data_we       = '0;
        tag_wdata     = '0;                 // invalid entry by default
        touch         = 1'b0;
        touch_way     = hit_way;
        case (state)
            dcache_pkg::INIT: begin
                ram_index = sweep_idx;
                tag_we    = '1;
                if (sweep_idx == dcache_pkg::index_t'(dcache_pkg::NUM_SETS - 1)) begin
                    next_state = dcache_pkg::IDLE;
                end
            end
            dcache_pkg::IDLE: begin
                cpu_req_ready = 1'b1;
                ram_index     = cpu_req.addr.index;  // arrays valid in LOOKUP
                if (cpu_req_valid) begin
                    next_state = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    cpu_rsp_valid = 1'b1;
                    touch         = 1'b1;
                    if (held_req.write) begin
                        tag_we[hit_way]  = 1'b1;
                        data_we[hit_way] = 1'b1;
                        tag_wdata.valid  = 1'b1;
                        tag_wdata.dirty  = 1'b1;
                        tag_wdata.tag    = held_req.addr.tag;
                    end
                    next_state = dcache_pkg::IDLE;
                end else if (victim_dirty) begin
                    next_state = dcache_pkg::WRITEBACK;
                end else begin
                    next_state = dcache_pkg::FETCH;
                end
            end
            dcache_pkg::WRITEBACK: begin
                mem_req_valid = 1'b1;
                mem_req.write = 1'b1;
                mem_req.addr  = victim_addr;
                mem_req.wdata = victim_line;
                if (mem_req_ready) begin
                    next_state = dcache_pkg::FETCH;
                end
            end
            dcache_pkg::FETCH: begin
                mem_req_valid = 1'b1;
                mem_req.addr  = dcache_pkg::line_addr_t'(fetch_addr);
                if (mem_req_ready) begin
                    next_state = dcache_pkg::WAIT_FILL;
                end
            end
            dcache_pkg::WAIT_FILL: begin
                if (mem_rsp_valid) begin
                    next_state = dcache_pkg::FILL;
                end
            end
            dcache_pkg::FILL: begin
                tag_we[victim_way]  = 1'b1;
                data_we[victim_way] = 1'b1;
                tag_wdata.valid     = 1'b1;
                tag_wdata.dirty     = held_req.write;  // clean after a read fill
                tag_wdata.tag       = held_req.addr.tag;
                cpu_rsp_valid       = 1'b1;
                touch               = 1'b1;
                touch_way           = victim_way;
                next_state          = dcache_pkg::IDLE;
            end
            default: next_state = dcache_pkg::INIT;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state, sweep counter and payload registers
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= dcache_pkg::INIT;
            sweep_idx <= '0;
        end else begin
            state <= next_state;
            if (state == dcache_pkg::INIT) begin
                sweep_idx <= sweep_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) begin
            held_req <= cpu_req;
        end
        if (state == dcache_pkg::WAIT_FILL && mem_rsp_valid) begin
            fill_line <= mem_rsp_line;
        end
    end

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

    a_rsp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_rsp_valid |=> !cpu_rsp_valid);

endmodule

//--- verilog/dcache_top.sv
//////////////////////////////////////////////////////////////////////
// dcache top level
// two-way write-back data cache with tag and data arrays, LRU state,
// way select and controller
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cpu_req_valid,
    output logic                  cpu_req_ready,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output logic                  cpu_rsp_valid,
    output dcache_pkg::word_t     cpu_rdata,
    output logic                  mem_req_valid,
    input  logic                  mem_req_ready,
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_rsp_valid,
    input  dcache_pkg::line_t     mem_rsp_line
);

    dcache_pkg::cpu_req_t                held_req;
    dcache_pkg::index_t                  ram_index;
    logic [dcache_pkg::NUM_WAYS-1:0]     tag_we;
    logic [dcache_pkg::NUM_WAYS-1:0]     data_we;
    dcache_pkg::tag_entry_t              tag_wdata;
    dcache_pkg::tag_entry_t              tag_rd [dcache_pkg::NUM_WAYS];
    dcache_pkg::line_t                   line_rd [dcache_pkg::NUM_WAYS];
    dcache_pkg::line_t                   new_line;
    logic                                filling;
    dcache_pkg::line_t                   fill_line;
    logic                                touch;
    dcache_pkg::way_t                    touch_way;
    dcache_pkg::way_t                    lru_way;
    logic                                hit;
    dcache_pkg::way_t                    hit_way;
    dcache_pkg::way_t                    victim_way;
    logic                                victim_dirty;
    dcache_pkg::line_addr_t              victim_addr;
    dcache_pkg::line_t                   victim_line;

    //////////////////////////////////////////////////////////////////////
    // arrays, one tag and one data ram per way
    //////////////////////////////////////////////////////////////////////
    for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
        dcache_way_ram #(.entry_t(dcache_pkg::tag_entry_t)) i_tag_ram (
            .clk(clk), .index(ram_index), .we(tag_we[w]),
            .wdata(tag_wdata), .rdata(tag_rd[w])
        );
        dcache_way_ram #(.entry_t(dcache_pkg::line_t)) i_data_ram (
            .clk(clk), .index(ram_index), .we(data_we[w]),
            .wdata(new_line), .rdata(line_rd[w])
        );
    end

    dcache_lru i_lru (
        .clk(clk), .rst_n(rst_n), .index(held_req.addr.index),
        .touch(touch), .touch_way(touch_way), .lru_way(lru_way)
    );

    dcache_way_select i_way_select (
        .req(held_req), .tag0(tag_rd[0]), .tag1(tag_rd[1]),
        .line0(line_rd[0]), .line1(line_rd[1]), .lru_way(lru_way),
        .filling(filling), .fill_line(fill_line), .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_dirty(victim_dirty),
        .victim_addr(victim_addr), .victim_line(victim_line),
        .rdata(cpu_rdata), .new_line(new_line)
    );

    dcache_ctrl i_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready),
        .cpu_req(cpu_req), .cpu_rsp_valid(cpu_rsp_valid),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req(mem_req), .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_line(mem_rsp_line), .held_req(held_req), .ram_index(ram_index),
        .tag_we(tag_we), .data_we(data_we), .tag_wdata(tag_wdata),
        .filling(filling), .fill_line(fill_line),
        .touch(touch), .touch_way(touch_way),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_addr(victim_addr),
        .victim_line(victim_line)
    );

endmodule

//--- testbench/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
// 100 ns clock, active low reset held for 4 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- testbench/tb_dcache.sv
//////////////////////////////////////////////////////////////////////
// dcache testbench
// random loads and stores over a few conflicting sets, memory model
// with random back-pressure and a word-level reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dcache;

    localparam int NUM_REQS      = 600;
    localparam int READY_TIMEOUT = 300;
    localparam int RSP_TIMEOUT   = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   cpu_req_valid;
    logic                   cpu_req_ready;
    dcache_pkg::cpu_req_t   cpu_req;
    logic                   cpu_rsp_valid;
    dcache_pkg::word_t      cpu_rdata;
    logic                   mem_req_valid;
    logic                   mem_req_ready;
    dcache_pkg::mem_req_t   mem_req;
    logic                   mem_rsp_valid;
    dcache_pkg::line_t      mem_rsp_line;

    dcache_pkg::word_t  shadow [logic [dcache_pkg::ADDR_W-1:0]];         // latest cpu writes
    bit                 written_lines [logic [dcache_pkg::LINE_ADDR_W-1:0]];
    dcache_pkg::line_t  mem_lines [logic [dcache_pkg::LINE_ADDR_W-1:0]]; // backing memory
    dcache_pkg::line_addr_t cur_line;     // line of the request in flight

    tb_clock i_clock (.clk(clk), .rst_n(rst_n));

    dcache_top i_dut (
        .clk(clk), .rst_n(rst_n),
        .cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready),
        .cpu_req(cpu_req), .cpu_rsp_valid(cpu_rsp_valid), .cpu_rdata(cpu_rdata),
        .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
        .mem_req(mem_req), .mem_rsp_valid(mem_rsp_valid), .mem_rsp_line(mem_rsp_line)
    );

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_word(input string name, input dcache_pkg::word_t expected,
                                input dcache_pkg::word_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAILED at %0t: %s expected %h actual %h",
                                      $time, name, expected, actual));
        end
    endtask

    task automatic compare_mem_req(input string name, input dcache_pkg::mem_req_t expected,
                                   input dcache_pkg::mem_req_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAILED at %0t: %s expected %h actual %h",
                                      $time, name, expected, actual));
        end
    endtask

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("FAILED at %0t: %s expected %b actual %b",
                                      $time, name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////
    // contents of a word never written, spread over the whole address
    function automatic dcache_pkg::word_t background_word(input dcache_pkg::word_addr_t a);
        return {2'b01, a} ^ 32'h9e37_79b9;
    endfunction

    function automatic dcache_pkg::word_t model_word(input dcache_pkg::word_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return background_word(a);
    endfunction

    function automatic dcache_pkg::line_addr_t line_of(input dcache_pkg::word_addr_t a);
        dcache_pkg::line_addr_t la;
        la.tag   = a.tag;
        la.index = a.index;
        return la;
    endfunction

    // line built from the model words, or from untouched memory
    function automatic dcache_pkg::line_t model_line(input dcache_pkg::line_addr_t la,
                                                     input bit from_model);
        dcache_pkg::line_t      line;
        dcache_pkg::word_addr_t wa;
        for (int i = 0; i < dcache_pkg::WORDS_PER_LINE; i++) begin
            wa = {la, dcache_pkg::offset_t'(i)};
            line[i*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] =
                from_model ? model_word(wa) : background_word(wa);
        end
        return line;
    endfunction

    // three tags on four sets, so a set often sees a third tag
    function automatic dcache_pkg::word_addr_t random_addr();
        dcache_pkg::word_addr_t a;
        case ($urandom % 3)
            0:       a.tag = 20'h0_0012;
            1:       a.tag = 20'h0_3a40;
            default: a.tag = 20'h8_1c05;
        endcase
        case ($urandom % 4)
            0:       a.index = 8'h00;
            1:       a.index = 8'h17;
            2:       a.index = 8'h80;
            default: a.index = 8'hff;
        endcase
        a.offset = dcache_pkg::offset_t'($urandom);
        return a;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////////////////////////
    initial begin
        dcache_pkg::mem_req_t   expected;
        dcache_pkg::mem_req_t   last_req;
        dcache_pkg::line_addr_t pend_addr;
        logic                   stalled;
        logic                   pending;
        int                     delay;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_line  = '0;
        stalled       = 1'b0;
        pending       = 1'b0;
        delay         = 0;
        forever begin
            @(posedge clk);
            if (stalled) begin                  // request must hold until accepted
                compare_bit("mem_req_valid", 1'b1, mem_req_valid);
                compare_mem_req("mem_req", last_req, mem_req);
            end
            stalled  = mem_req_valid && !mem_req_ready;
            last_req = mem_req;
            if (mem_req_valid && mem_req_ready) begin
                expected.write = mem_req.write;
                expected.addr  = mem_req.write ? mem_req.addr : cur_line;
                expected.wdata = mem_req.wdata;
                if (mem_req.write) begin
                    if (!written_lines.exists(mem_req.addr)) begin
                        stop_with_error("write-back of a line that the CPU never wrote");
                    end
                    expected.wdata = model_line(mem_req.addr, 1'b1);
                    mem_lines[mem_req.addr] = mem_req.wdata;
                end else begin
                    pending   = 1'b1;
                    pend_addr = mem_req.addr;
                    delay     = 1 + int'($urandom % 8);
                end
                compare_mem_req("mem_req", expected, mem_req);
            end
            mem_rsp_valid <= 1'b0;
            if (pending) begin
                delay--;
                if (delay == 0) begin
                    pending       = 1'b0;
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_line  <= mem_lines.exists(pend_addr) ? mem_lines[pend_addr]
                                                                : model_line(pend_addr, 1'b0);
                end
            end
            mem_req_ready <= ($urandom % 4) != 0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // cpu side
    //////////////////////////////////////////////////////////////////////
    task automatic wait_ready_after_reset();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            compare_bit("cpu_rsp_valid", 1'b0, cpu_rsp_valid);
            compare_bit("mem_req_valid", 1'b0, mem_req_valid);
            if (rst_n) n++;
            if (n > READY_TIMEOUT) begin
                stop_with_error("cpu_req_ready did not rise within 300 cycles of reset");
            end
        end while (!(rst_n && cpu_req_ready));
    endtask

    task automatic wait_accept(input dcache_pkg::cpu_req_t req);
        int n;
        logic accepted;
        n = 0;
        accepted = 1'b0;
        cpu_req_valid <= 1'b1;
        cpu_req       <= req;
        while (!accepted) begin
            @(posedge clk);
            compare_bit("cpu_rsp_valid", 1'b0, cpu_rsp_valid);
            accepted = cpu_req_ready;
            n++;
            if (!accepted && n > RSP_TIMEOUT) begin
                stop_with_error("CPU request was not accepted in time");
            end
        end
        cpu_req_valid <= 1'b0;
    endtask

    task automatic wait_response(input dcache_pkg::cpu_req_t req,
                                 input dcache_pkg::word_t exp_rdata, input logic repeat_hit);
        int n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            n++;
            if (repeat_hit && n == 1) begin     // hit answers right after acceptance
                compare_bit("cpu_rsp_valid", 1'b1, cpu_rsp_valid);
                compare_bit("mem_req_valid", 1'b0, mem_req_valid);
            end
            if (cpu_rsp_valid) begin
                if (!req.write) compare_word("cpu_rdata", exp_rdata, cpu_rdata);
                done = 1'b1;
            end else if (n > RSP_TIMEOUT) begin
                stop_with_error("no CPU response for an accepted request");
            end
        end
    endtask

    initial begin
        dcache_pkg::cpu_req_t   req;
        dcache_pkg::word_addr_t last_addr;
        dcache_pkg::word_t      exp_rdata;
        logic                   repeat_hit;
        void'($urandom(32'h82826396));
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        last_addr     = '0;
        wait_ready_after_reset();
        for (int k = 0; k < NUM_REQS; k++) begin
            repeat_hit = (k > 0) && ($urandom % 4 == 0);
            req.addr   = repeat_hit ? last_addr : random_addr();
            req.write  = ($urandom % 2) == 1;
            req.wdata  = $urandom;
            wait_accept(req);
            exp_rdata = model_word(req.addr);
            cur_line  = line_of(req.addr);
            if (req.write) begin
                shadow[req.addr]        = req.wdata;
                written_lines[cur_line] = 1'b1;
            end
            wait_response(req, exp_rdata, repeat_hit);
            last_addr = req.addr;
            repeat ($urandom % 3) begin         // idle gap, no stray responses
                @(posedge clk);
                compare_bit("cpu_rsp_valid", 1'b0, cpu_rsp_valid);
            end
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- project.f
verilog/dcache_pkg.sv
verilog/dcache_way_ram.sv
verilog/dcache_lru.sv
verilog/dcache_way_select.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
testbench/tb_clock.sv
testbench/tb_dcache.sv

//--- Makefile
# Verilator build and run for the dcache testbench

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Finished with no errors

SOURCES := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
